// File: design/dda_timer.sv
`timescale 1ns/1ns

module dda_timer
  import stepper_motion_pkg::*;
(
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic [7:0]               clock_divisor,
  input  logic [DDA_WIDTH-1:0]     move_duration,
  input  logic [DDA_WIDTH-1:0]     increment,
  input  logic [DDA_WIDTH-1:0]     incrementincrement,
  input  logic [MOVE_BUF_SIZE-1:0] stepready,
  output logic                     step,
  output logic [MOVE_IDX_BITS-1:0] moveind,
  output logic [MOVE_BUF_SIZE-1:0] stepfinished,
  output logic                     move_done
);

  logic [7:0]           prescale;
  logic                 active;
  logic [DDA_WIDTH-1:0] tick_count;
  logic [DDA_WIDTH-1:0] accumulator;
  logic [DDA_WIDTH-1:0] inc_r;
  logic [DDA_WIDTH:0]   acc_sum;

  // Divisor of 0 wraps to a 256 cycle tick
  wire tick      = (prescale >= clock_divisor - 8'd1);
  wire pending   = stepready[moveind] ^ stepfinished[moveind];
  wire last_tick = (tick_count + DDA_WIDTH'(1) >= move_duration);

  // Carry out of the accumulator is the step
  assign acc_sum = {1'b0, accumulator} + {1'b0, inc_r};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      prescale <= 8'd0;
    end else if (tick) begin
      prescale <= 8'd0;
    end else begin
      prescale <= prescale + 8'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active       <= 1'b0;
      step         <= 1'b0;
      move_done    <= 1'b0;
      moveind      <= '0;
      stepfinished <= '0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (tick) begin
        if (!active) begin
          // Start tick only loads the move
          if (pending) begin
            active <= 1'b1;
          end
        end else begin
          step <= acc_sum[DDA_WIDTH];
          if (last_tick) begin
            active                <= 1'b0;
            stepfinished[moveind] <= ~stepfinished[moveind];
            moveind               <= moveind + MOVE_IDX_BITS'(1);
            move_done             <= 1'b1;
          end
        end
      end
    end
  end

  // Increment restarts from the slot value for every move
  always_ff @(posedge CLK) begin
    if (tick) begin
      if (!active) begin
        accumulator <= '0;
        inc_r       <= increment;
        tick_count  <= '0;
      end else begin
        accumulator <= acc_sum[DDA_WIDTH-1:0];
        inc_r       <= inc_r + incrementincrement;
        tick_count  <= tick_count + DDA_WIDTH'(1);
      end
    end
  end

endmodule

// File: design/spi_state_machine.sv
`timescale 1ns/1ns

module spi_state_machine
  import stepper_cmd_pkg::*;
  import stepper_motion_pkg::*;
(
  input  logic                             CLK,
  input  logic                             resetn,
  input  logic                             word_received,
  input  logic [63:0]                      word_data,
  input  logic [63:0]                      encoder_count,
  input  logic [MOVE_IDX_BITS-1:0]         moveind,
  input  logic [MOVE_BUF_SIZE-1:0]         stepfinished,
  output logic [63:0]                      word_send_data,
  output logic [MOVE_BUF_SIZE-1:0]         stepready,
  output logic [MOTOR_COUNT-1:0]           dir_out,
  output logic [DDA_WIDTH-1:0]             move_duration,
  output logic [MOTOR_COUNT*DDA_WIDTH-1:0] increment,
  output logic [MOTOR_COUNT*DDA_WIDTH-1:0] incrementincrement,
  output logic [7:0]                       clock_divisor,
  output logic [MOTOR_COUNT-1:0]           enable,
  output logic                             buffer_dtr,
  output logic [2:0]                       microsteps,
  output logic [7:0]                       current,
  output logic [9:0]                       config_offtime,
  output logic [7:0]                       config_blanktime,
  output logic [9:0]                       config_fastdecay_threshold,
  output logic [7:0]                       config_minimum_on_time,
  output logic [10:0]                      config_current_threshold,
  output logic [7:0]                       config_chargepump_period,
  output logic                             config_invert_highside,
  output logic                             config_invert_lowside
);

  logic                     word_strobe;
  logic [7:0]               message_header;
  logic [7:0]               message_word_count;
  logic [MOVE_IDX_BITS-1:0] writemoveind;
  logic [63:0]              encoder_store;

  // Move buffer, one entry per slot
  logic [MOTOR_COUNT-1:0] dir_r        [MOVE_BUF_SIZE];
  logic [DDA_WIDTH-1:0]   duration_mem [MOVE_BUF_SIZE];
  logic [DDA_WIDTH-1:0]   inc_mem      [MOVE_BUF_SIZE][MOTOR_COUNT];
  logic [DDA_WIDTH-1:0]   incinc_mem   [MOVE_BUF_SIZE][MOTOR_COUNT];

  wire [7:0] header = word_data[63:56];

  // Header still open, so the next word belongs to the same message
  wire awaiting_more_words = (message_header == CMD_COORDINATED_STEP) ||
                             (message_header == CMD_API_VERSION);
  wire header_word = word_strobe && !awaiting_more_words;
  wire move_word   = word_strobe && (message_header == CMD_COORDINATED_STEP);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      microsteps                 <= DEFAULT_MICROSTEPS;
      current                    <= DEFAULT_CURRENT;
      config_offtime             <= DEFAULT_OFFTIME;
      config_blanktime           <= DEFAULT_BLANKTIME;
      config_fastdecay_threshold <= DEFAULT_FASTDECAY_THRESHOLD;
      config_minimum_on_time     <= DEFAULT_MINIMUM_ON_TIME;
      config_current_threshold   <= DEFAULT_CURRENT_THRESHOLD;
      config_chargepump_period   <= DEFAULT_CHARGEPUMP_PERIOD;
      config_invert_highside     <= DEFAULT_BRIDGE_INVERTING;
      config_invert_lowside      <= DEFAULT_BRIDGE_INVERTING;
      clock_divisor              <= DEFAULT_CLOCK_DIVISOR;
      enable                     <= '0;
      word_send_data             <= 64'd0;
      word_strobe                <= 1'b0;
      message_header             <= 8'd0;
      message_word_count         <= 8'd0;
      writemoveind               <= '0;
      stepready                  <= '0;
      for (int s = 0; s < MOVE_BUF_SIZE; s++) begin
        dir_r[s] <= '0;
      end
    end else begin
      word_strobe <= word_received;
      if (word_strobe) begin
        // Reply is cleared unless this word prepares one
        word_send_data <= 64'd0;
        if (!awaiting_more_words) begin
          message_header     <= header;
          message_word_count <= 8'd1;
          case (header)
            CMD_COORDINATED_STEP: begin
              dir_r[writemoveind] <= word_data[MOTOR_COUNT-1:0];
            end
            CMD_MOTOR_ENABLE: begin
              enable <= word_data[MOTOR_COUNT-1:0];
            end
            CMD_CLK_DIVISOR: begin
              clock_divisor <= word_data[7:0];
            end
            CMD_MOTORCONFIG: begin
              current    <= word_data[15:8];
              microsteps <= word_data[2:0];
            end
            // Minimum on time shares bits with the fast decay threshold
            CMD_MICROSTEPPER_CONFIG: begin
              config_offtime             <= word_data[39:30];
              config_blanktime           <= word_data[29:22];
              config_fastdecay_threshold <= word_data[21:12];
              config_minimum_on_time     <= word_data[18:11];
              config_current_threshold   <= word_data[10:0];
            end
            CMD_CHARGEPUMP: begin
              config_chargepump_period <= word_data[7:0];
            end
            CMD_BRIDGEINVERT: begin
              config_invert_highside <= word_data[1];
              config_invert_lowside  <= word_data[0];
            end
            CMD_API_VERSION: begin
              word_send_data <= {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            end
            default: begin
            end
          endcase
        end else begin
          message_word_count <= message_word_count + 8'd1;
          if (message_header == CMD_COORDINATED_STEP) begin
            // First increment word returns the header-time encoder count
            if (message_word_count == 8'd2) begin
              word_send_data <= encoder_store;
            end
            if (message_word_count == 8'(2 * MOTOR_COUNT + 1)) begin
              writemoveind            <= writemoveind + MOVE_IDX_BITS'(1);
              stepready[writemoveind] <= ~stepready[writemoveind];
              message_header          <= 8'd0;
              message_word_count      <= 8'd0;
            end
          end else begin
            message_header <= 8'd0;
          end
        end
      end
    end
  end

  // Slot contents and encoder snapshot
  always_ff @(posedge CLK) begin
    if (header_word && (header == CMD_COORDINATED_STEP)) begin
      encoder_store <= encoder_count;
    end
    if (move_word) begin
      if (message_word_count == 8'd1) begin
        duration_mem[writemoveind] <= word_data;
      end
      for (int m = 0; m < MOTOR_COUNT; m++) begin
        if (message_word_count == 8'(2 * m + 2)) begin
          inc_mem[writemoveind][m] <= word_data;
        end
        if (message_word_count == 8'(2 * m + 3)) begin
          incinc_mem[writemoveind][m] <= word_data;
        end
      end
    end
  end

  // The slot being played feeds every DDA
  assign move_duration = duration_mem[moveind];
  assign dir_out       = dir_r[moveind];

  for (genvar m = 0; m < MOTOR_COUNT; m++) begin : g_slot_out
    assign increment[m*DDA_WIDTH +: DDA_WIDTH]          = inc_mem[moveind][m];
    assign incrementincrement[m*DDA_WIDTH +: DDA_WIDTH] = incinc_mem[moveind][m];
  end

  // Free slot exists when not every slot is pending
  assign buffer_dtr = ~&(stepready ^ stepfinished);

endmodule

// File: design/spi_word_rx.sv
`timescale 1ns/1ns

module spi_word_rx (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        SCK,
  input  logic        CS,
  input  logic        COPI,
  output logic        CIPO,
  input  logic [63:0] word_send_data,
  output logic        word_received,
  output logic [63:0] word_data
);

  // Two synchronizer stages, third stage for edge detection
  logic [2:0]  sck_r;
  logic [2:0]  cs_r;
  logic [1:0]  copi_r;
  logic [5:0]  bit_count;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;

  wire sck_rise  = sck_r[1] & ~sck_r[2];
  wire sck_fall  = ~sck_r[1] & sck_r[2];
  wire cs_fall   = ~cs_r[1] & cs_r[2];
  wire cs_active = ~cs_r[1];

  // COPI sampled in step with the synchronized SCK
  wire [63:0] rx_next = {rx_shift[62:0], copi_r[1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;
      copi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], SCK};
      cs_r   <= {cs_r[1:0], CS};
      copi_r <= {copi_r[0], COPI};
    end
  end

  // Bit counter wraps after 64 bits, CS high restarts the word
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count     <= 6'd0;
      word_received <= 1'b0;
    end else begin
      word_received <= 1'b0;
      if (!cs_active) begin
        bit_count <= 6'd0;
      end else if (sck_rise) begin
        bit_count <= bit_count + 6'd1;
        if (bit_count == 6'd63) begin
          word_received <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= rx_next;
      if (bit_count == 6'd63) begin
        word_data <= rx_next;
      end
    end
  end

  // Reply loaded at CS fall so the MSB is valid before the first rise
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= 64'd0;
    end else if (cs_fall) begin
      tx_shift <= word_send_data;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  assign CIPO = tx_shift[63];

endmodule

// File: design/stepper_cmd_pkg.sv
package stepper_cmd_pkg;

  // Command codes, carried in the top byte of a header word
  localparam logic [7:0] CMD_COORDINATED_STEP    = 8'h01;
  localparam logic [7:0] CMD_MOTOR_ENABLE        = 8'h0a;
  localparam logic [7:0] CMD_CLK_DIVISOR         = 8'h0b;
  localparam logic [7:0] CMD_MOTORCONFIG         = 8'h10;
  localparam logic [7:0] CMD_MICROSTEPPER_CONFIG = 8'h16;
  localparam logic [7:0] CMD_CHARGEPUMP          = 8'h1b;
  localparam logic [7:0] CMD_BRIDGEINVERT        = 8'h1c;
  localparam logic [7:0] CMD_API_VERSION         = 8'hfe;

  // Firmware version returned on readback
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd3;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // Motor driver defaults
  localparam logic [2:0]  DEFAULT_MICROSTEPS = 3'd2;
  localparam logic [7:0]  DEFAULT_CURRENT    = 8'd140;

  // Microstepper timing defaults
  localparam logic [9:0]  DEFAULT_OFFTIME             = 10'd810;
  localparam logic [7:0]  DEFAULT_BLANKTIME           = 8'd27;
  localparam logic [9:0]  DEFAULT_FASTDECAY_THRESHOLD = 10'd706;
  localparam logic [7:0]  DEFAULT_MINIMUM_ON_TIME     = 8'd54;
  localparam logic [10:0] DEFAULT_CURRENT_THRESHOLD   = 11'd1024;

  // Charge pump and bridge polarity
  localparam logic [7:0]  DEFAULT_CHARGEPUMP_PERIOD = 8'd91;
  localparam logic        DEFAULT_BRIDGE_INVERTING  = 1'b0;

  // 40 gives a 400 kHz DDA tick from a 16 MHz clock
  localparam logic [7:0]  DEFAULT_CLOCK_DIVISOR = 8'd40;

endpackage

// File: design/stepper_motion_pkg.sv
package stepper_motion_pkg;

  // Number of axes driven by the controller
  localparam int MOTOR_COUNT = 2;

  // Move buffer depth and slot index width
  localparam int MOVE_BUF_SIZE = 2;
  localparam int MOVE_IDX_BITS = 1;

  // Duration, increment, increment-of-increment and accumulator width
  localparam int DDA_WIDTH = 64;

endpackage

// File: design/stepper_top.sv
`timescale 1ns/1ns

module stepper_top
  import stepper_motion_pkg::*;
(
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   SCK,
  input  logic                   CS,
  input  logic                   COPI,
  output logic                   CIPO,
  input  logic [63:0]            encoder_count,
  output logic [MOTOR_COUNT-1:0] step,
  output logic [MOTOR_COUNT-1:0] dir,
  output logic [MOTOR_COUNT-1:0] enable,
  output logic [2:0]             microsteps,
  output logic [7:0]             current,
  output logic [9:0]             config_offtime,
  output logic [7:0]             config_blanktime,
  output logic [9:0]             config_fastdecay_threshold,
  output logic [7:0]             config_minimum_on_time,
  output logic [10:0]            config_current_threshold,
  output logic [7:0]             config_chargepump_period,
  output logic                   config_invert_highside,
  output logic                   config_invert_lowside,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  logic                             word_received;
  logic [63:0]                      word_data;
  logic [63:0]                      word_send_data;
  logic [MOVE_BUF_SIZE-1:0]         stepready;
  logic [MOVE_BUF_SIZE-1:0]         stepfinished;
  logic [MOVE_IDX_BITS-1:0]         moveind;
  logic [DDA_WIDTH-1:0]             move_duration;
  logic [MOTOR_COUNT*DDA_WIDTH-1:0] increment;
  logic [MOTOR_COUNT*DDA_WIDTH-1:0] incrementincrement;
  logic [7:0]                       clock_divisor;

  spi_word_rx u_rx (.*);

  spi_state_machine u_decoder (
    .*,
    .dir_out (dir)
  );

  // All timers run in lockstep, axis 0 reports buffer progress
  for (genvar i = 0; i < MOTOR_COUNT; i++) begin : g_axis
    if (i == 0) begin : g_lead
      dda_timer u_dda (
        .CLK                (CLK),
        .resetn             (resetn),
        .clock_divisor      (clock_divisor),
        .move_duration      (move_duration),
        .increment          (increment[i*DDA_WIDTH +: DDA_WIDTH]),
        .incrementincrement (incrementincrement[i*DDA_WIDTH +: DDA_WIDTH]),
        .stepready          (stepready),
        .step               (step[i]),
        .moveind            (moveind),
        .stepfinished       (stepfinished),
        .move_done          (move_done)
      );
    end else begin : g_follow
      dda_timer u_dda (
        .CLK                (CLK),
        .resetn             (resetn),
        .clock_divisor      (clock_divisor),
        .move_duration      (move_duration),
        .increment          (increment[i*DDA_WIDTH +: DDA_WIDTH]),
        .incrementincrement (incrementincrement[i*DDA_WIDTH +: DDA_WIDTH]),
        .stepready          (stepready),
        .step               (step[i]),
        .moveind            (),
        .stepfinished       (),
        .move_done          ()
      );
    end
  end

endmodule

// File: dv/stepper_sva.sv
`timescale 1ns/1ns

module stepper_sva
  import stepper_motion_pkg::*;
(
  input logic                   CLK,
  input logic                   resetn,
  input logic [MOTOR_COUNT-1:0] step,
  input logic                   move_done,
  input logic                   buffer_dtr
);

  // A step pulse lasts exactly one clock on every axis
  for (genvar i = 0; i < MOTOR_COUNT; i++) begin : g_step
    step_single_cycle: assert property (
      @(posedge CLK) disable iff (!resetn) step[i] |=> !step[i]
    ) else $error("step[%0d] stayed high for two cycles", i);
  end

  move_done_single_cycle: assert property (
    @(posedge CLK) disable iff (!resetn) move_done |=> !move_done
  ) else $error("move_done stayed high for two cycles");

  // Both slots free once reset has been applied
  dtr_after_reset: assert property (
    @(posedge CLK) !resetn |=> buffer_dtr
  ) else $error("buffer_dtr low after reset");

endmodule

// File: dv/stepper_tb.sv
`timescale 1ns/1ns

module stepper_tb
  import stepper_cmd_pkg::*;
  import stepper_motion_pkg::*;
();

  localparam int SPI_HALF = 5;

  logic                   CLK;
  logic                   resetn;
  logic                   SCK;
  logic                   CS;
  logic                   COPI;
  logic                   CIPO;
  logic [63:0]            encoder_count;
  logic [MOTOR_COUNT-1:0] step;
  logic [MOTOR_COUNT-1:0] dir;
  logic [MOTOR_COUNT-1:0] enable;
  logic [2:0]             microsteps;
  logic [7:0]             current;
  logic [7:0]             config_blanktime;
  logic [7:0]             config_minimum_on_time;
  logic [7:0]             config_chargepump_period;
  logic [9:0]             config_offtime;
  logic [9:0]             config_fastdecay_threshold;
  logic [10:0]            config_current_threshold;
  logic                   config_invert_highside;
  logic                   config_invert_lowside;
  logic                   buffer_dtr;
  logic                   move_done;

  integer seed;
  int     error_count;
  int     tests_run;
  int     tests_passed;
  int     step_total [MOTOR_COUNT];
  int     done_total;

  stepper_top uut (.*);

  bind stepper_top stepper_sva u_sva (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (step),
    .move_done  (move_done),
    .buffer_dtr (buffer_dtr)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Pulse counters sampled on the falling edge
  always @(negedge CLK) begin
    for (int m = 0; m < MOTOR_COUNT; m++) begin
      if (step[m]) begin
        step_total[m]++;
      end
    end
    if (move_done) begin
      done_total++;
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // One mode 0 word, MSB first; CIPO is read just before each rising SCK
  task automatic send_word(input logic [63:0] data, output logic [63:0] reply);
    logic [63:0] shift_in;
    shift_in = 64'd0;
    CS = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      COPI = data[i];
      repeat (SPI_HALF) @(negedge CLK);
      shift_in = {shift_in[62:0], CIPO};
      SCK = 1'b1;
      repeat (SPI_HALF) @(negedge CLK);
      SCK = 1'b0;
    end
    CS = 1'b1;
    repeat (8) @(negedge CLK);
    reply = shift_in;
  endtask

  // Header, duration, then increment and zero increment-of-increment per motor
  task automatic send_move(input logic [MOTOR_COUNT-1:0] dirs, input logic [63:0] duration,
                           input logic [63:0] inc0, input logic [63:0] inc1,
                           input logic [63:0] encoder_after, output logic [63:0] encoder_reply);
    logic [63:0] reply;
    send_word({CMD_COORDINATED_STEP, 56'(dirs)}, reply);
    encoder_count = encoder_after;
    send_word(duration, reply);
    send_word(inc0, reply);
    send_word(64'd0, encoder_reply);
    send_word(inc1, reply);
    send_word(64'd0, reply);
  endtask

  task automatic wait_move_done(input int limit, input string where);
    int cycles;
    cycles = 0;
    while (move_done !== 1'b1 && cycles < limit) begin
      @(negedge CLK);
      cycles++;
    end
    if (move_done !== 1'b1) begin
      $display("Timed out after %0d cycles waiting for move_done in %s", limit, where);
      error_count++;
    end else begin
      @(negedge CLK);
    end
  endtask

  initial begin
    logic [63:0]            payload;
    logic [63:0]            reply;
    logic [63:0]            enc_value;
    logic [MOTOR_COUNT-1:0] dir_bits;
    int                     errors_before;
    int                     steps0_start;
    int                     steps1_start;
    int                     done_start;

    seed = 32'h8d11_b338;
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    encoder_count = 64'd0;
    repeat (3) @(negedge CLK);
    resetn = 1'b1;
    repeat (2) @(negedge CLK);

    errors_before = error_count;
    check_value("microsteps", 64'(microsteps), 64'd2);
    check_value("current", 64'(current), 64'd140);
    check_value("config_offtime", 64'(config_offtime), 64'd810);
    check_value("config_blanktime", 64'(config_blanktime), 64'd27);
    check_value("config_fastdecay_threshold", 64'(config_fastdecay_threshold), 64'd706);
    check_value("config_minimum_on_time", 64'(config_minimum_on_time), 64'd54);
    check_value("config_current_threshold", 64'(config_current_threshold), 64'd1024);
    check_value("config_chargepump_period", 64'(config_chargepump_period), 64'd91);
    check_value("config_invert_highside", 64'(config_invert_highside), 64'd0);
    check_value("config_invert_lowside", 64'(config_invert_lowside), 64'd0);
    check_value("step", 64'(step), 64'd0);
    check_value("enable", 64'(enable), 64'd0);
    check_value("move_done", 64'(move_done), 64'd0);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_value("CIPO", 64'(CIPO), 64'd0);
    report_test("reset values", errors_before);

    errors_before = error_count;
    payload = {$random(seed), $random(seed)};
    payload[63:56] = CMD_MOTORCONFIG;
    send_word(payload, reply);
    check_value("current", 64'(current), 64'(payload[15:8]));
    check_value("microsteps", 64'(microsteps), 64'(payload[2:0]));
    payload = {$random(seed), $random(seed)};
    payload[63:56] = CMD_MICROSTEPPER_CONFIG;
    send_word(payload, reply);
    check_value("config_offtime", 64'(config_offtime), 64'(payload[39:30]));
    check_value("config_blanktime", 64'(config_blanktime), 64'(payload[29:22]));
    check_value("config_fastdecay_threshold", 64'(config_fastdecay_threshold),
                64'(payload[21:12]));
    check_value("config_minimum_on_time", 64'(config_minimum_on_time), 64'(payload[18:11]));
    check_value("config_current_threshold", 64'(config_current_threshold),
                64'(payload[10:0]));
    payload = {$random(seed), $random(seed)};
    payload[63:56] = CMD_CHARGEPUMP;
    send_word(payload, reply);
    check_value("config_chargepump_period", 64'(config_chargepump_period), 64'(payload[7:0]));
    payload = {$random(seed), $random(seed)};
    payload[63:56] = CMD_BRIDGEINVERT;
    send_word(payload, reply);
    check_value("config_invert_highside", 64'(config_invert_highside), 64'(payload[1]));
    check_value("config_invert_lowside", 64'(config_invert_lowside), 64'(payload[0]));
    payload = {$random(seed), $random(seed)};
    payload[63:56] = CMD_MOTOR_ENABLE;
    send_word(payload, reply);
    check_value("enable", 64'(enable), 64'(payload[MOTOR_COUNT-1:0]));
    report_test("configuration commands", errors_before);

    // The reply to a word is shifted out during the word after it
    errors_before = error_count;
    send_word({CMD_API_VERSION, 56'd0}, reply);
    send_word(64'd0, reply);
    check_value("version reply", 64'(reply[23:0]),
                64'({VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}));
    report_test("version readback", errors_before);

    // 2^62 per tick carries once every 4 ticks, so 40 ticks give 10 steps
    errors_before = error_count;
    send_word({CMD_CLK_DIVISOR, 56'd4}, reply);
    dir_bits = MOTOR_COUNT'($random(seed));
    steps0_start = step_total[0];
    steps1_start = step_total[1];
    done_start = done_total;
    send_move(dir_bits, 64'd40, 64'h4000_0000_0000_0000, 64'd0, encoder_count, reply);
    check_value("dir", 64'(dir), 64'(dir_bits));
    wait_move_done(1000, "single-motor move");
    repeat (20) @(negedge CLK);
    check_value("step[0] pulse count", 64'(step_total[0] - steps0_start), 64'd10);
    check_value("step[1] pulse count", 64'(step_total[1] - steps1_start), 64'd0);
    check_value("move_done pulse count", 64'(done_total - done_start), 64'd1);
    report_test("single-motor move", errors_before);

    errors_before = error_count;
    enc_value = {$random(seed), $random(seed)};
    encoder_count = enc_value;
    send_move('0, 64'd4, 64'd0, 64'd0, ~enc_value, reply);
    check_value("encoder readback", reply, enc_value);
    wait_move_done(1000, "encoder move");
    report_test("encoder readback", errors_before);

    // The first move outlasts the transfer of the second
    errors_before = error_count;
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    send_move('0, 64'd3000, 64'h4000_0000_0000_0000, 64'd0, encoder_count, reply);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    send_move('0, 64'd3000, 64'd0, 64'h4000_0000_0000_0000, encoder_count, reply);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd0);
    wait_move_done(20000, "first queued move");
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    wait_move_done(20000, "second queued move");
    report_test("flow control", errors_before);

    $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the stepper testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module stepper_tb \
  --Mdir obj_dir \
  -o stepper_sim \
  -f stepper_top.f

./obj_dir/stepper_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without a reported failure"

// File: stepper_top.f
design/stepper_cmd_pkg.sv
design/stepper_motion_pkg.sv
design/spi_word_rx.sv
design/spi_state_machine.sv
design/dda_timer.sv
design/stepper_top.sv
dv/stepper_sva.sv
dv/stepper_tb.sv
